// File: test/dual_issue_golden.txt
// Pair count, then one line per pair: pc inst_a inst_b
// Result count, then one line per result in program order: pc rd data
13
00000100 80800005 81001FFD  // ADDI r1 = 5, ADDI r2 = -3
00000108 91800ABC 12044000  // LUI r3, ADD r4 = r1 + r2
00000110 22844000 63048000  // SUB r5, SLL r6 by r4
00000118 73882000 54044000  // SRL r7, XOR r8
00000120 3488A000 4504A000  // AND r9, OR r10
00000128 85840010 162C2000  // Split, B reads r11
00000130 80040007 16802000  // Write to r0, B reads r0
00000138 87000001 87000002  // Both slots write r14
00000140 00000000 17B9C000  // NOP, r15 = r14 + r14
00000148 88400001 18C22000  // Burst of split pairs, r16 += 1, r17 += r16
00000150 88400001 18C22000
00000158 88400001 18C22000
00000160 88400001 18C22000
00000168 88400001 18C22000
00000170 88400001 18C22000
00000178 88400001 18C22000
00000180 88400001 18C22000
00000188 88400001 18C22000
00000190 88400001 18C22000
25
00000100 01 00000005
00000104 02 FFFFFFFD
00000108 03 55E00000
0000010C 04 00000002
00000110 05 00000008
00000114 06 00000014
00000118 07 07FFFFFF
0000011C 08 FFFFFFF8
00000120 09 00000008
00000124 0A 0000000D
00000128 0B 00000015
0000012C 0C 0000001A
00000130 00 0000000C
00000134 0D 00000005
00000138 0E 00000001
0000013C 0E 00000002
00000144 0F 00000004
00000148 10 00000001
0000014C 11 00000001
00000150 10 00000002
00000154 11 00000003
00000158 10 00000003
0000015C 11 00000006
00000160 10 00000004
00000164 11 0000000A
00000168 10 00000005
0000016C 11 0000000F
00000170 10 00000006
00000174 11 00000015
00000178 10 00000007
0000017C 11 0000001C
00000180 10 00000008
00000184 11 00000024
00000188 10 00000009
0000018C 11 0000002D
00000190 10 0000000A
00000194 11 00000037

// File: dual_issue_core.f
+incdir+src
src/issue_pkg.sv
src/issue_ifs.sv
src/inst_decoder.sv
src/issue_queue.sv
src/reg_file.sv
src/issue_exe.sv
src/exe_alu.sv
src/dual_issue_core.sv
test/dual_issue_core_assert.sv
test/dual_issue_core_tb.sv

// File: Makefile
FLIST = dual_issue_core.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f $(FLIST) --top-module dual_issue_core

# Pass only when the run prints the pass message
sim:
	verilator --binary --timing --assert -f $(FLIST) --top-module dual_issue_core_tb -Mdir obj_dir
	./obj_dir/Vdual_issue_core_tb +verilator+error+limit+100 | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: test/dual_issue_core_tb.sv
`timescale 1ns/1ps

module dual_issue_core_tb;
    import issue_pkg::*;

    logic        clk;
    logic        rstn;
    logic        i_valid;
    logic        o_ready;
    word_t       i_pc;
    word_t       i_inst_a;
    word_t       i_inst_b;
    logic        o_wb_valid_a;
    word_t       o_wb_pc_a;
    reg_idx_t    o_wb_rd_a;
    word_t       o_wb_data_a;
    logic        o_wb_valid_b;
    word_t       o_wb_pc_b;
    reg_idx_t    o_wb_rd_b;
    word_t       o_wb_data_b;

    logic [31:0] gold [0:255];   // Raw words of the golden file
    word_t       pair_pc [$];
    word_t       pair_a [$];
    word_t       pair_b [$];
    word_t       exp_pc [$];     // Expected stream, program order
    reg_idx_t    exp_rd [$];
    word_t       exp_data [$];
    int          n_pairs;
    int          n_exp;
    int          got;            // Results seen so far
    int          checks;
    int          errors;
    int          stall_cycles;   // Input held off during the burst
    logic        in_burst;
    logic [31:0] rng;

    dual_issue_core UUT (
        .clk          (clk),
        .rstn         (rstn),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_pc         (i_pc),
        .i_inst_a     (i_inst_a),
        .i_inst_b     (i_inst_b),
        .o_wb_valid_a (o_wb_valid_a),
        .o_wb_pc_a    (o_wb_pc_a),
        .o_wb_rd_a    (o_wb_rd_a),
        .o_wb_data_a  (o_wb_data_a),
        .o_wb_valid_b (o_wb_valid_b),
        .o_wb_pc_b    (o_wb_pc_b),
        .o_wb_rd_b    (o_wb_rd_b),
        .o_wb_data_b  (o_wb_data_b)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;   // 10 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Count word, pair lines, count word, result lines
    task automatic load_golden();
        int base;
        int k;
        $readmemh("test/dual_issue_golden.txt", gold);
        n_pairs = int'(gold[0]);
        for (k = 0; k < n_pairs; k++) begin
            pair_pc.push_back(gold[1 + 3 * k]);
            pair_a.push_back(gold[2 + 3 * k]);
            pair_b.push_back(gold[3 + 3 * k]);
        end
        base  = 1 + 3 * n_pairs;
        n_exp = int'(gold[base]);
        for (k = 0; k < n_exp; k++) begin
            exp_pc.push_back(gold[base + 1 + 3 * k]);
            exp_rd.push_back(reg_idx_t'(gold[base + 2 + 3 * k]));
            exp_data.push_back(gold[base + 3 + 3 * k]);
        end
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Next entry of the stream against the next expected entry
    task automatic check_result(input word_t pc, input reg_idx_t rd, input word_t data);
        if (got >= n_exp) begin
            errors++;
            $display("Extra result beyond the expected stream at pc %h", pc);
        end else begin
            compare_word($sformatf("result %0d pc", got), exp_pc[got], pc);
            compare_reg($sformatf("result %0d rd", got), exp_rd[got], rd);
            compare_word($sformatf("result %0d data", got), exp_data[got], data);
        end
        got++;
    endtask

    // Hold the pair until a rising edge sees o_ready
    task automatic send_pair(input word_t pc, input word_t a, input word_t b);
        logic taken;
        i_valid  = 1'b1;
        i_pc     = pc;
        i_inst_a = a;
        i_inst_b = b;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = o_ready;     // Settled mid cycle
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Writeback monitor, slot A before slot B
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rstn) begin
            if (in_burst && i_valid && !o_ready) begin
                stall_cycles++;
            end
            if (o_wb_valid_a) begin
                check_result(o_wb_pc_a, o_wb_rd_a, o_wb_data_a);
            end
            if (o_wb_valid_b) begin
                check_result(o_wb_pc_b, o_wb_rd_b, o_wb_data_b);
            end
        end
    end

    initial begin : main
        int p;
        int idle;
        rstn         = 1'b0;
        i_valid      = 1'b0;
        i_pc         = '0;
        i_inst_a     = '0;
        i_inst_b     = '0;
        in_burst     = 1'b0;
        got          = 0;
        checks       = 0;
        errors       = 0;
        stall_cycles = 0;
        rng          = 32'ha1ab_64c6;
        load_golden();
        repeat (2) @(posedge clk);
        #1 rstn = 1'b1;
        for (p = 0; p < n_pairs; p++) begin
            in_burst = (p >= n_pairs / 2);   // Later half is the dependent burst
            if (!in_burst) begin
                rng  = xorshift32(rng);
                idle = int'(rng % 4);
                i_valid = 1'b0;
                repeat (idle) begin
                    @(posedge clk);
                    #1;
                end
            end
            send_pair(pair_pc[p], pair_a[p], pair_b[p]);
        end
        i_valid  = 1'b0;
        in_burst = 1'b0;
        wait (got >= n_exp);
        repeat (5) @(posedge clk);           // Window for a duplicate
        if (stall_cycles == 0) begin
            errors++;
            $display("o_ready never dropped, the queue did not fill during the burst");
        end
        errors = errors + UUT.u_assert.fail_count;
        $display("Results %0d of %0d, checks %0d, stall cycles %0d, errors %0d",
                 got, n_exp, checks, stall_cycles, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // 40 cycles per pair plus pipeline fill and drain
    initial begin : watchdog
        @(posedge rstn);
        repeat (40 * n_pairs + 100) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived, errors %0d", got, n_exp, errors);
        $display("Test failed");
        $finish;
    end

endmodule

// File: test/dual_issue_core_assert.sv
`timescale 1ns/1ps

module dual_issue_core_assert (
    input logic                clk,
    input logic                rstn,
    input logic                i_pair_valid,   // Decoder to queue stream
    input logic                i_pair_ready,
    input issue_pkg::pc_set_t  i_set_a,
    input issue_pkg::pc_set_t  i_set_b,
    input logic                i_wb_valid_a,
    input logic                i_wb_valid_b,
    input issue_pkg::ex_slot_t i_ex_a,   // issue_exe outputs
    input issue_pkg::ex_slot_t i_ex_b
);
    import issue_pkg::*;

    int fail_count = 0;   // Failed assertions so far

    a_wb_quiet_in_reset: assert property (@(posedge clk)
        !rstn |-> (!i_wb_valid_a && !i_wb_valid_b))
    else begin
        fail_count++;
        $error("writeback valid while in reset");
    end

    // A split pair never leaves B beside the A it depends on
    a_no_pair_raw: assert property (@(posedge clk) disable iff (!rstn)
        (i_ex_a.valid && i_ex_a.rf_we && i_ex_b.valid) |->
        !((i_ex_b.op1_reg && (i_ex_b.rs1 == i_ex_a.rd)) ||
          (i_ex_b.op2_reg && (i_ex_b.rs2 == i_ex_a.rd))))
    else begin
        fail_count++;
        $error("slot B issued with a source written by slot A");
    end

    // Decoded pair waits unchanged while the queue is full
    a_pair_held: assert property (@(posedge clk) disable iff (!rstn)
        (i_pair_valid && !i_pair_ready) |=>
        (i_pair_valid && $stable(i_set_a) && $stable(i_set_b)))
    else begin
        fail_count++;
        $error("decoded pair changed while the queue was not ready");
    end

endmodule

bind dual_issue_core dual_issue_core_assert u_assert (
    .clk          (clk),
    .rstn         (rstn),
    .i_pair_valid (dec_q.valid),
    .i_pair_ready (dec_q.ready),
    .i_set_a      (dec_q.set_a),
    .i_set_b      (dec_q.set_b),
    .i_wb_valid_a (o_wb_valid_a),
    .i_wb_valid_b (o_wb_valid_b),
    .i_ex_a       (ex_a),
    .i_ex_b       (ex_b)
);

// File: src/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_valid,
    output logic                o_ready,
    input  issue_pkg::word_t    i_pc,
    input  issue_pkg::word_t    i_inst_a,
    input  issue_pkg::word_t    i_inst_b,
    output logic                o_wb_valid_a,
    output issue_pkg::word_t    o_wb_pc_a,
    output issue_pkg::reg_idx_t o_wb_rd_a,
    output issue_pkg::word_t    o_wb_data_a,
    output logic                o_wb_valid_b,
    output issue_pkg::word_t    o_wb_pc_b,
    output issue_pkg::reg_idx_t o_wb_rd_b,
    output issue_pkg::word_t    o_wb_data_b
);
    import issue_pkg::*;

    issue_slot_if dec_q ();   // Decoder to queue
    issue_slot_if q_iss ();   // Queue to issue
    rf_read_if    rf_rd ();
    rf_write_if   rf_wr ();

    ex_slot_t ex_a;
    ex_slot_t ex_b;

    inst_decoder u_dec (
        .clk      (clk),
        .rstn     (rstn),
        .i_valid  (i_valid),
        .o_ready  (o_ready),
        .i_pc     (i_pc),
        .i_inst_a (i_inst_a),
        .i_inst_b (i_inst_b),
        .o_pair   (dec_q.up)
    );

    issue_queue u_queue (
        .clk    (clk),
        .rstn   (rstn),
        .i_pair (dec_q.down),
        .o_pair (q_iss.up)
    );

    issue_exe u_issue (
        .clk    (clk),
        .rstn   (rstn),
        .i_pair (q_iss.down),
        .o_rd   (rf_rd.reader),
        .o_ex_a (ex_a),
        .o_ex_b (ex_b)
    );

    exe_alu u_alu (
        .clk          (clk),
        .rstn         (rstn),
        .i_ex_a       (ex_a),
        .i_ex_b       (ex_b),
        .o_wr         (rf_wr.writer),
        .o_wb_valid_a (o_wb_valid_a),
        .o_wb_pc_a    (o_wb_pc_a),
        .o_wb_rd_a    (o_wb_rd_a),
        .o_wb_data_a  (o_wb_data_a),
        .o_wb_valid_b (o_wb_valid_b),
        .o_wb_pc_b    (o_wb_pc_b),
        .o_wb_rd_b    (o_wb_rd_b),
        .o_wb_data_b  (o_wb_data_b)
    );

    reg_file u_rf (
        .clk  (clk),
        .rstn (rstn),
        .i_rd (rf_rd.file),
        .i_wr (rf_wr.file)
    );

endmodule

// File: src/exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
    input  logic                clk,
    input  logic                rstn,
    input  issue_pkg::ex_slot_t i_ex_a,
    input  issue_pkg::ex_slot_t i_ex_b,
    rf_write_if.writer          o_wr,
    output logic                o_wb_valid_a,
    output issue_pkg::word_t    o_wb_pc_a,
    output issue_pkg::reg_idx_t o_wb_rd_a,
    output issue_pkg::word_t    o_wb_data_a,
    output logic                o_wb_valid_b,
    output issue_pkg::word_t    o_wb_pc_b,
    output issue_pkg::reg_idx_t o_wb_rd_b,
    output issue_pkg::word_t    o_wb_data_b
);
    import issue_pkg::*;

    ex_slot_t   ex [2];         // Index 0 is slot A
    word_t      res [2];
    logic [1:0] wb_vld_q;       // Reported result
    logic [1:0] wb_we_q;        // Register write
    word_t      wb_pc_q [2];
    reg_idx_t   wb_rd_q [2];
    word_t      wb_data_q [2];

    // Writeback to execute forwarding, slot B checked last so it wins
    function automatic word_t fwd(input word_t val, input logic from_reg, input reg_idx_t rs);
        word_t v;
        v = val;
        for (int w = 0; w < 2; w++) begin
            if (from_reg && wb_we_q[w] && (wb_rd_q[w] == rs)) begin
                v = wb_data_q[w];
            end
        end
        return v;
    endfunction

    function automatic word_t alu(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_AND:    return a & b;
            ALU_OR:     return a | b;
            ALU_XOR:    return a ^ b;
            ALU_SLL:    return a << b[4:0];   // Low 5 bits only
            ALU_SRL:    return a >> b[4:0];
            default:    return b;             // PASS_B for LUI
        endcase
    endfunction

    assign ex[0] = i_ex_a;
    assign ex[1] = i_ex_b;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            res[i] = alu(ex[i].alu_op,
                         fwd(ex[i].op1, ex[i].op1_reg, ex[i].rs1),
                         fwd(ex[i].op2, ex[i].op2_reg, ex[i].rs2));
        end
    end

    ////////////////////////////////////////////////////////////
    // Writeback registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_vld_q <= '0;
            wb_we_q  <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                wb_vld_q[i] <= ex[i].valid && !ex[i].is_nop;  // rd 0 still reported
                wb_we_q[i]  <= ex[i].valid && ex[i].rf_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            wb_pc_q[i]   <= ex[i].pc;
            wb_rd_q[i]   <= ex[i].rd;
            wb_data_q[i] <= res[i];
        end
    end

    // Register file takes the same values one edge later
    assign o_wr.we      = wb_we_q;
    assign o_wr.addr[0] = wb_rd_q[0];
    assign o_wr.addr[1] = wb_rd_q[1];
    assign o_wr.data[0] = wb_data_q[0];
    assign o_wr.data[1] = wb_data_q[1];

    assign o_wb_valid_a = wb_vld_q[0];
    assign o_wb_pc_a    = wb_pc_q[0];
    assign o_wb_rd_a    = wb_rd_q[0];
    assign o_wb_data_a  = wb_data_q[0];
    assign o_wb_valid_b = wb_vld_q[1];
    assign o_wb_pc_b    = wb_pc_q[1];
    assign o_wb_rd_b    = wb_rd_q[1];
    assign o_wb_data_b  = wb_data_q[1];

endmodule

// File: src/issue_exe.sv
`timescale 1ns/1ps

module issue_exe (
    input  logic                clk,
    input  logic                rstn,
    issue_slot_if.down          i_pair,
    rf_read_if.reader           o_rd,
    output issue_pkg::ex_slot_t o_ex_a,
    output issue_pkg::ex_slot_t o_ex_b
);
    import issue_pkg::*;

    pc_set_t  sa;       // Head slot A
    pc_set_t  sb;       // Head slot B
    logic     dep;      // B reads what A writes
    logic     hold_q;   // A already gone, B pending
    logic     vld_a_q;
    logic     vld_b_q;
    ex_slot_t ex_a_q;
    ex_slot_t ex_b_q;

    // Build one execute slot from a decoded slot and its read data
    function automatic ex_slot_t mk_slot(input pc_set_t s, input word_t r1, input word_t r2);
        ex_slot_t e;
        e.valid   = s.valid;
        e.pc      = s.pc;
        e.alu_op  = s.alu_op;
        e.rd      = s.rd;
        e.rf_we   = s.rf_we;
        e.is_nop  = s.is_nop;
        e.rs1     = s.rs1;
        e.rs2     = s.rs2;
        e.op1     = r1;
        e.op2     = (s.src2_sel == SRC2_IMM) ? s.imm : r2;
        e.op1_reg = (s.rs1 != '0);
        e.op2_reg = (s.src2_sel == SRC2_REG) && (s.rs2 != '0);
        return e;
    endfunction

    assign sa = i_pair.set_a;
    assign sb = i_pair.set_b;

    // Unused sources are zero and rf_we implies rd != 0
    assign dep = sa.valid && sa.rf_we && sb.valid &&
                 ((sb.rs1 == sa.rd) || (sb.rs2 == sa.rd));

    // Head stays one cycle longer on a split
    assign i_pair.ready = hold_q || !dep;

    assign o_rd.addr[0] = sa.rs1;
    assign o_rd.addr[1] = sa.rs2;
    assign o_rd.addr[2] = sb.rs1;
    assign o_rd.addr[3] = sb.rs2;

    ////////////////////////////////////////////////////////////
    // Execute register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_q  <= 1'b0;
            vld_a_q <= 1'b0;
            vld_b_q <= 1'b0;
        end else begin
            hold_q  <= i_pair.valid && dep && !hold_q;        // Set on first half only
            vld_a_q <= i_pair.valid && sa.valid && !hold_q;   // A never reissued
            vld_b_q <= i_pair.valid && sb.valid && (hold_q || !dep);
        end
    end

    always_ff @(posedge clk) begin
        ex_a_q <= mk_slot(sa, o_rd.data[0], o_rd.data[1]);
        ex_b_q <= mk_slot(sb, o_rd.data[2], o_rd.data[3]);
    end

    // Valid bits come from the reset flops
    always_comb begin
        o_ex_a       = ex_a_q;
        o_ex_a.valid = vld_a_q;
        o_ex_b       = ex_b_q;
        o_ex_b.valid = vld_b_q;
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "issue_settings.svh"

module reg_file (
    input  logic     clk,
    input  logic     rstn,
    rf_read_if.file  i_rd,
    rf_write_if.file i_wr
);
    import issue_pkg::*;

    word_t regs [`ISSUE_NREGS];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < `ISSUE_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Port 1 after port 0, so slot B wins on the same rd
            for (int p = 0; p < 2; p++) begin
                if (i_wr.we[p] && (i_wr.addr[p] != '0)) begin
                    regs[i_wr.addr[p]] <= i_wr.data[p];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reads with write-through bypass
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            i_rd.data[p] = regs[i_rd.addr[p]];
            for (int w = 0; w < 2; w++) begin
                if (i_wr.we[w] && (i_wr.addr[w] == i_rd.addr[p])) begin
                    i_rd.data[p] = i_wr.data[w];  // Later port overrides
                end
            end
            if (i_rd.addr[p] == '0) begin
                i_rd.data[p] = '0;                // r0 reads zero
            end
        end
    end

endmodule

// File: src/issue_queue.sv
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_queue (
    input  logic       clk,
    input  logic       rstn,
    issue_slot_if.down i_pair,
    issue_slot_if.up   o_pair
);
    import issue_pkg::*;

    localparam int DEPTH = `ISSUE_QUEUE_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);
    localparam logic [CW-1:0] FULL = CW'(DEPTH);

    pc_set_t       mem_a [DEPTH];  // Slot A storage
    pc_set_t       mem_b [DEPTH];  // Slot B storage
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    // Circular increment, depth need not be a power of two
    function automatic logic [PW-1:0] nxt(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + PW'(1);
    endfunction

    // Full queue still takes a pair when the head leaves this edge
    assign i_pair.ready = (count != FULL) || o_pair.ready;
    assign push         = i_pair.valid && i_pair.ready;
    assign pop          = o_pair.valid && o_pair.ready;

    assign o_pair.valid = (count != '0);
    assign o_pair.set_a = mem_a[rd_ptr];
    assign o_pair.set_b = mem_b[rd_ptr];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= nxt(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= nxt(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_a[wr_ptr] <= i_pair.set_a;
            mem_b[wr_ptr] <= i_pair.set_b;
        end
    end

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_valid,
    output logic             o_ready,
    input  issue_pkg::word_t i_pc,
    input  issue_pkg::word_t i_inst_a,
    input  issue_pkg::word_t i_inst_b,
    issue_slot_if.up         o_pair
);
    import issue_pkg::*;

    logic rdy_en;  // Held low until the first edge after reset

    // Field split and opcode mapping for one word
    function automatic pc_set_t decode(input word_t inst, input word_t pc);
        pc_set_t s;
        s          = '0;
        s.valid    = 1'b1;
        s.pc       = pc;
        s.rd       = inst[27:23];
        s.rs1      = inst[22:18];
        s.rs2      = inst[17:13];
        s.imm      = {{(`ISSUE_XLEN-13){inst[12]}}, inst[12:0]};  // Sign extend
        s.src2_sel = SRC2_REG;
        s.alu_op   = ALU_ADD;
        case (opcode_e'(inst[31:28]))
            OP_ADD:  s.alu_op = ALU_ADD;
            OP_SUB:  s.alu_op = ALU_SUB;
            OP_AND:  s.alu_op = ALU_AND;
            OP_OR:   s.alu_op = ALU_OR;
            OP_XOR:  s.alu_op = ALU_XOR;
            OP_SLL:  s.alu_op = ALU_SLL;
            OP_SRL:  s.alu_op = ALU_SRL;
            OP_ADDI: begin
                s.src2_sel = SRC2_IMM;
                s.rs2      = '0;                     // No false dependence on rs2
            end
            OP_LUI: begin
                s.alu_op   = ALU_PASS_B;
                s.src2_sel = SRC2_IMM;
                s.imm      = {inst[12:0], {(`ISSUE_XLEN-13){1'b0}}};  // Bits 31..19
                s.rs1      = '0;
                s.rs2      = '0;
            end
            default: begin                           // NOP and unused codes
                s.is_nop = 1'b1;
                s.rd     = '0;
                s.rs1    = '0;
                s.rs2    = '0;
            end
        endcase
        s.rf_we = !s.is_nop && (s.rd != '0);
        return s;
    endfunction

    // Accept when the output register is empty or being taken
    assign o_ready = rdy_en && (!o_pair.valid || o_pair.ready);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdy_en       <= 1'b0;
            o_pair.valid <= 1'b0;
        end else begin
            rdy_en <= 1'b1;
            if (o_ready) begin
                o_pair.valid <= i_valid;
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            o_pair.set_a <= decode(i_inst_a, i_pc);
            o_pair.set_b <= decode(i_inst_b, i_pc + word_t'(4));  // Slot B is pc + 4
        end
    end

endmodule

// File: src/issue_ifs.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Decoded pair stream with valid/ready
////////////////////////////////////////////////////////////
interface issue_slot_if;
    import issue_pkg::*;

    logic    valid;
    logic    ready;
    pc_set_t set_a;   // Older slot
    pc_set_t set_b;   // Younger slot

    modport up   (output valid, output set_a, output set_b, input  ready);
    modport down (input  valid, input  set_a, input  set_b, output ready);
endinterface

////////////////////////////////////////////////////////////
// Register file reads, combinational
////////////////////////////////////////////////////////////
interface rf_read_if;
    import issue_pkg::*;

    reg_idx_t [3:0] addr;  // a.rs1, a.rs2, b.rs1, b.rs2
    word_t    [3:0] data;

    modport reader (output addr, input  data);
    modport file   (input  addr, output data);
endinterface

////////////////////////////////////////////////////////////
// Register file writes, index 0 is slot A
////////////////////////////////////////////////////////////
interface rf_write_if;
    import issue_pkg::*;

    logic     [1:0] we;
    reg_idx_t [1:0] addr;
    word_t    [1:0] data;

    modport writer (output we, output addr, output data);
    modport file   (input  we, input  addr, input  data);
endinterface

// File: src/issue_pkg.sv
`include "issue_settings.svh"

package issue_pkg;

    typedef logic [`ISSUE_XLEN-1:0]          word_t;    // Data or pc
    typedef logic [$clog2(`ISSUE_NREGS)-1:0] reg_idx_t; // Register index

    // Top 4 bits of the instruction word
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_ADDI = 4'd8,
        OP_LUI  = 4'd9
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // LUI result is op2 as is
    } alu_op_e;

    typedef enum logic {
        SRC2_REG,
        SRC2_IMM
    } src2_sel_e;

    // One decoded slot as it sits in the queue
    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        reg_idx_t  rd;
        reg_idx_t  rs1;       // Zero when not read
        reg_idx_t  rs2;       // Zero when not read
        word_t     imm;       // Already extended, or shifted for LUI
        src2_sel_e src2_sel;
        logic      rf_we;     // Low for NOP and rd 0
        logic      is_nop;    // NOP produces no writeback report
    } pc_set_t;

    // One slot of the execute register
    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     rf_we;
        logic     is_nop;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    op1;
        word_t    op2;
        logic     op1_reg;    // op1 read from a nonzero register
        logic     op2_reg;    // op2 read from a nonzero register
    } ex_slot_t;

endpackage

// File: src/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Decoded pairs held between decode and issue
`define ISSUE_QUEUE_DEPTH 4

// Datapath width
`define ISSUE_XLEN 32

// Architectural registers, r0 reads as zero
`define ISSUE_NREGS 32

`endif
